// File: hdl/server_consts.svh
////////////////////////////////////////
// sizes and CSR map of the server shell
// included by the package and by any RTL file using these sizes
////////////////////////////////////////
`ifndef SERVER_CONSTS_SVH
`define SERVER_CONSTS_SVH

// worker threads
`define NUM_FTHREADS      4
`define FT_ID_W           2

// tags: host tag is {thread number, thread tag}
`define FT_TAG_W          8
`define CCI_TAG_W         10

// cache-line address and data line
`define ADDR_W            32
`define DATA_W            64

// host CSR space
`define CSR_ADDR_W        14
`define CSR_DATA_W        32
`define CSR_JOB_ARG_ADDR  14'h0a8
`define CSR_CMD_ADDR      14'h0ac

`endif

// File: hdl/server_pkg.sv
////////////////////////////////////////
// types shared by the server shell blocks
////////////////////////////////////////
`default_nettype none

`include "server_consts.svh"

package server_pkg;

    // command in the low bits of a CMD write
    typedef enum logic [1:0] {
        OP_NONE       = 2'd0,
        OP_SOFT_RESET = 2'd1,
        OP_START_JOB  = 2'd2
    } cmd_opcode_e;

    // per-thread dispatch state
    typedef enum logic {
        FT_IDLE = 1'b0,
        FT_BUSY = 1'b1
    } ft_state_e;

    typedef struct packed {
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_DATA_W-1:0] data;
    } csr_wr_t;

    // thread number on top selects the target thread
    typedef struct packed {
        logic [`FT_ID_W-1:0]              ft_id;
        logic [`CSR_DATA_W-`FT_ID_W-1:0]  payload;
    } job_t;

    typedef struct packed {
        logic [`ADDR_W-1:0]   addr;
        logic [`FT_TAG_W-1:0] tag;
    } ft_rd_req_t;

    typedef struct packed {
        logic [`ADDR_W-1:0]    addr;
        logic [`CCI_TAG_W-1:0] tag;
    } cci_rd_hdr_t;

    typedef struct packed {
        logic [`CCI_TAG_W-1:0] tag;
        logic [`DATA_W-1:0]    data;
    } cci_rd_rsp_t;

    typedef struct packed {
        logic [`FT_TAG_W-1:0] tag;
        logic [`DATA_W-1:0]   data;
    } ft_rd_rsp_t;

endpackage

`default_nettype wire

// File: hdl/server_io.sv
////////////////////////////////////////
// host side of the server shell
// double-registers the receive channels, issues read requests
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module server_io (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     soft_rst_n,
    // host receive channels
    input  logic                     cci_rx_rd_valid,
    input  server_pkg::cci_rd_rsp_t  cci_rx_rd,
    input  logic                     cci_rx_cfg_valid,
    input  server_pkg::csr_wr_t      cci_rx_cfg,
    // host read request channel
    input  logic                     cci_tx_rd_almostfull,
    output logic                     spl_tx_rd_valid,
    output server_pkg::cci_rd_hdr_t  spl_tx_rd_hdr,
    // toward cmd_server
    output logic                     csr_valid,
    output server_pkg::csr_wr_t      csr,
    // toward response_router
    output logic                     rsp_valid,
    output server_pkg::cci_rd_rsp_t  rsp,
    // from read_arbiter
    input  logic                     rq_valid,
    input  server_pkg::cci_rd_hdr_t  rq_hdr,
    output logic                     rq_ready
);

    ////////////////////////////////////////
    // receive registers
    ////////////////////////////////////////

    logic                     rd_v1;
    logic                     rd_v2;
    logic                     cfg_v1;
    logic                     cfg_v2;
    server_pkg::cci_rd_rsp_t  rd_q1;
    server_pkg::cci_rd_rsp_t  rd_q2;
    server_pkg::csr_wr_t      cfg_q1;
    server_pkg::csr_wr_t      cfg_q2;

    // strobes, cleared by either reset
    always_ff @(posedge clk) begin
        if (!soft_rst_n) begin
            rd_v1  <= 1'b0;
            rd_v2  <= 1'b0;
            cfg_v1 <= 1'b0;
            cfg_v2 <= 1'b0;
        end else begin
            rd_v1  <= cci_rx_rd_valid;
            rd_v2  <= rd_v1;
            cfg_v1 <= cci_rx_cfg_valid;
            cfg_v2 <= cfg_v1;
        end
    end

    // payload follows the strobes
    always_ff @(posedge clk) begin
        rd_q1  <= cci_rx_rd;
        rd_q2  <= rd_q1;
        cfg_q1 <= cci_rx_cfg;
        cfg_q2 <= cfg_q1;
    end

    // second stage split by channel
    assign csr_valid = cfg_v2;
    assign csr       = cfg_q2;
    assign rsp_valid = rd_v2;
    assign rsp       = rd_q2;

    ////////////////////////////////////////
    // read request issue
    ////////////////////////////////////////

    logic                     tx_v;
    server_pkg::cci_rd_hdr_t  tx_hdr;

    // held entry leaves whenever almost-full is low,
    // so a new one can be taken in the same cycle
    assign rq_ready = ~cci_tx_rd_almostfull;

    always_ff @(posedge clk) begin
        if (!soft_rst_n) begin
            tx_v <= 1'b0;
        end else if (rq_ready) begin
            tx_v <= rq_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rq_valid && rq_ready) begin
            tx_hdr <= rq_hdr;
        end
    end

    // never strobe the host while it is almost full
    assign spl_tx_rd_valid = tx_v & ~cci_tx_rd_almostfull;
    assign spl_tx_rd_hdr   = tx_hdr;

    // host sends one receive message per cycle on this port
    a_rx_one_hot : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(cci_rx_rd_valid && cci_rx_cfg_valid)
    );

endmodule

`default_nettype wire

// File: hdl/cmd_server.sv
////////////////////////////////////////
// CSR command decode, soft reset and job dispatch
// one job in flight per thread, released by its done pulse
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "server_consts.svh"

module cmd_server (
    input  logic                          clk,
    input  logic                          rst_n,
    // CSR writes from server_io
    input  logic                          csr_valid,
    input  server_pkg::csr_wr_t           csr,
    // reset to the other blocks and threads
    output logic                          soft_rst_n,
    output logic [`NUM_FTHREADS-1:0]      ft_reset,
    // jobs to the threads
    output server_pkg::job_t              fthread_job [`NUM_FTHREADS],
    output logic [`NUM_FTHREADS-1:0]      fthread_job_valid,
    input  logic [`NUM_FTHREADS-1:0]      fthread_done
);

    logic                      is_arg;
    logic                      is_cmd;
    logic                      sr_cmd;
    logic                      start_cmd;
    logic                      sr_q;
    server_pkg::cmd_opcode_e   opcode;
    server_pkg::job_t          job_q;
    server_pkg::ft_state_e     ft_state [`NUM_FTHREADS];
    logic [`NUM_FTHREADS-1:0]  start_hit;

    ////////////////////////////////////////
    // CSR decode
    ////////////////////////////////////////

    assign is_arg = csr_valid && (csr.addr == `CSR_JOB_ARG_ADDR);
    assign is_cmd = csr_valid && (csr.addr == `CSR_CMD_ADDR);
    assign opcode = server_pkg::cmd_opcode_e'(csr.data[1:0]);

    always_comb begin
        sr_cmd    = 1'b0;
        start_cmd = 1'b0;
        if (is_cmd) begin
            case (opcode)
                server_pkg::OP_SOFT_RESET: sr_cmd    = 1'b1;
                server_pkg::OP_START_JOB:  start_cmd = 1'b1;
                server_pkg::OP_NONE:       sr_cmd    = 1'b0;
                default:                   sr_cmd    = 1'b0;
            endcase
        end
    end

    // job word waits here for the next start
    always_ff @(posedge clk) begin
        if (is_arg) begin
            job_q <= server_pkg::job_t'(csr.data);
        end
    end

    ////////////////////////////////////////
    // soft reset
    ////////////////////////////////////////

    // one-cycle pulse, only the hard reset clears it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sr_q <= 1'b0;
        end else begin
            sr_q <= sr_cmd;
        end
    end

    // single reset seen by the rest of the shell
    assign soft_rst_n = rst_n & ~sr_q;
    assign ft_reset   = {`NUM_FTHREADS{sr_q}};

    ////////////////////////////////////////
    // dispatch
    ////////////////////////////////////////

    // start reaches only an idle target
    always_comb begin
        for (int i = 0; i < `NUM_FTHREADS; i++) begin
            start_hit[i] = start_cmd && (job_q.ft_id == i) &&
                           (ft_state[i] == server_pkg::FT_IDLE);
        end
    end

    always_ff @(posedge clk) begin
        if (!soft_rst_n) begin
            fthread_job_valid <= '0;
            for (int i = 0; i < `NUM_FTHREADS; i++) begin
                ft_state[i] <= server_pkg::FT_IDLE;
            end
        end else begin
            fthread_job_valid <= start_hit;
            for (int i = 0; i < `NUM_FTHREADS; i++) begin
                if (start_hit[i]) begin
                    ft_state[i] <= server_pkg::FT_BUSY;
                end else if (fthread_done[i]) begin
                    ft_state[i] <= server_pkg::FT_IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_FTHREADS; i++) begin
            if (start_hit[i]) begin
                fthread_job[i] <= job_q;
            end
        end
    end

    // a thread only reports done for a job it was given
    for (genvar g = 0; g < `NUM_FTHREADS; g++) begin : g_done_chk
        a_done_busy : assert property (
            @(posedge clk) disable iff (!soft_rst_n)
            fthread_done[g] |-> ft_state[g] == server_pkg::FT_BUSY
        );
    end

endmodule

`default_nettype wire

// File: hdl/read_arbiter.sv
////////////////////////////////////////
// round-robin merge of thread read requests
// one output slot, host tag carries the thread number
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "server_consts.svh"

module read_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          soft_rst_n,
    // thread side
    input  logic [`NUM_FTHREADS-1:0]      ft_rd_valid,
    input  server_pkg::ft_rd_req_t        ft_rd_req [`NUM_FTHREADS],
    output logic [`NUM_FTHREADS-1:0]      ft_rd_ready,
    // toward server_io
    output logic                          rq_valid,
    output server_pkg::cci_rd_hdr_t       rq_hdr,
    input  logic                          rq_ready
);

    logic [`FT_ID_W-1:0]      last_q;
    logic [`FT_ID_W-1:0]      win_id;
    logic                     win_found;
    logic                     can_load;
    logic                     slot_v;
    server_pkg::cci_rd_hdr_t  slot_hdr;

    // slot free now or leaving this cycle
    assign can_load = ~slot_v | rq_ready;

    // search starts one past the last winner
    always_comb begin
        logic [`FT_ID_W-1:0] idx;
        win_found = 1'b0;
        win_id    = '0;
        for (int k = 1; k <= `NUM_FTHREADS; k++) begin
            idx = last_q + `FT_ID_W'(k);
            if (!win_found && ft_rd_valid[idx]) begin
                win_found = 1'b1;
                win_id    = idx;
            end
        end
    end

    // with nobody asking every thread sees ready
    always_comb begin
        for (int i = 0; i < `NUM_FTHREADS; i++) begin
            ft_rd_ready[i] = can_load && (!win_found || (win_id == i));
        end
    end

    always_ff @(posedge clk) begin
        if (!soft_rst_n) begin
            slot_v <= 1'b0;
            last_q <= `FT_ID_W'(`NUM_FTHREADS - 1);
        end else if (can_load && win_found) begin
            slot_v <= 1'b1;
            last_q <= win_id;
        end else if (rq_ready) begin
            slot_v <= 1'b0;
        end
    end

    // tag = {thread number, thread tag}
    always_ff @(posedge clk) begin
        if (can_load && win_found) begin
            slot_hdr.addr <= ft_rd_req[win_id].addr;
            slot_hdr.tag  <= {win_id, ft_rd_req[win_id].tag};
        end
    end

    assign rq_valid = slot_v;
    assign rq_hdr   = slot_hdr;

    // no two threads handed off in the same cycle
    a_one_xfer : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(ft_rd_valid & ft_rd_ready)
    );

endmodule

`default_nettype wire

// File: hdl/response_router.sv
////////////////////////////////////////
// steers host read responses to threads by host tag
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "server_consts.svh"

module response_router (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          soft_rst_n,
    // from server_io
    input  logic                          rsp_valid,
    input  server_pkg::cci_rd_rsp_t       rsp,
    // toward threads
    output logic [`NUM_FTHREADS-1:0]      ft_rx_valid,
    output server_pkg::ft_rd_rsp_t        ft_rx [`NUM_FTHREADS]
);

    logic [`FT_ID_W-1:0]   tid;
    logic [`FT_TAG_W-1:0]  ft_tag;

    // thread number sits in the top bits of the host tag
    assign tid    = rsp.tag[`CCI_TAG_W-1 -: `FT_ID_W];
    assign ft_tag = rsp.tag[`FT_TAG_W-1:0];

    always_ff @(posedge clk) begin
        if (!soft_rst_n) begin
            ft_rx_valid <= '0;
        end else begin
            for (int i = 0; i < `NUM_FTHREADS; i++) begin
                ft_rx_valid[i] <= rsp_valid && (tid == i);
            end
        end
    end

    // only the addressed thread's payload moves
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_FTHREADS; i++) begin
            if (rsp_valid && (tid == i)) begin
                ft_rx[i].tag  <= ft_tag;
                ft_rx[i].data <= rsp.data;
            end
        end
    end

    // tag must name an existing thread
    a_tid_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid |-> !$isunknown(tid) && (int'(tid) < `NUM_FTHREADS)
    );

endmodule

`default_nettype wire

// File: hdl/fpga_server.sv
////////////////////////////////////////
// server shell top, host port on one side, worker threads on the other
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "server_consts.svh"

module fpga_server (
    input  logic                          clk,
    input  logic                          rst_n,
    // host receive
    input  logic                          cci_rx_rd_valid,
    input  server_pkg::cci_rd_rsp_t       cci_rx_rd,
    input  logic                          cci_rx_cfg_valid,
    input  server_pkg::csr_wr_t           cci_rx_cfg,
    // host read request
    input  logic                          cci_tx_rd_almostfull,
    output logic                          spl_tx_rd_valid,
    output server_pkg::cci_rd_hdr_t       spl_tx_rd_hdr,
    // thread read requests
    input  logic [`NUM_FTHREADS-1:0]      ft_rd_valid,
    input  server_pkg::ft_rd_req_t        ft_rd_req [`NUM_FTHREADS],
    output logic [`NUM_FTHREADS-1:0]      ft_rd_ready,
    // thread read responses
    output logic [`NUM_FTHREADS-1:0]      ft_rx_valid,
    output server_pkg::ft_rd_rsp_t        ft_rx [`NUM_FTHREADS],
    // jobs
    output server_pkg::job_t              fthread_job [`NUM_FTHREADS],
    output logic [`NUM_FTHREADS-1:0]      fthread_job_valid,
    input  logic [`NUM_FTHREADS-1:0]      fthread_done,
    output logic [`NUM_FTHREADS-1:0]      ft_reset
);

    logic                     soft_rst_n;
    logic                     csr_valid;
    server_pkg::csr_wr_t      csr;
    logic                     rsp_valid;
    server_pkg::cci_rd_rsp_t  rsp;
    logic                     rq_valid;
    server_pkg::cci_rd_hdr_t  rq_hdr;
    logic                     rq_ready;

    ////////////////////////////////////////
    // host side
    ////////////////////////////////////////

    server_io u_server_io (
        .clk                  (clk),
        .rst_n                (rst_n),
        .soft_rst_n           (soft_rst_n),
        .cci_rx_rd_valid      (cci_rx_rd_valid),
        .cci_rx_rd            (cci_rx_rd),
        .cci_rx_cfg_valid     (cci_rx_cfg_valid),
        .cci_rx_cfg           (cci_rx_cfg),
        .cci_tx_rd_almostfull (cci_tx_rd_almostfull),
        .spl_tx_rd_valid      (spl_tx_rd_valid),
        .spl_tx_rd_hdr        (spl_tx_rd_hdr),
        .csr_valid            (csr_valid),
        .csr                  (csr),
        .rsp_valid            (rsp_valid),
        .rsp                  (rsp),
        .rq_valid             (rq_valid),
        .rq_hdr               (rq_hdr),
        .rq_ready             (rq_ready)
    );

    // commands, also source of the soft reset
    cmd_server u_cmd_server (
        .clk                  (clk),
        .rst_n                (rst_n),
        .csr_valid            (csr_valid),
        .csr                  (csr),
        .soft_rst_n           (soft_rst_n),
        .ft_reset             (ft_reset),
        .fthread_job          (fthread_job),
        .fthread_job_valid    (fthread_job_valid),
        .fthread_done         (fthread_done)
    );

    ////////////////////////////////////////
    // thread side
    ////////////////////////////////////////

    read_arbiter u_read_arbiter (
        .clk                  (clk),
        .rst_n                (rst_n),
        .soft_rst_n           (soft_rst_n),
        .ft_rd_valid          (ft_rd_valid),
        .ft_rd_req            (ft_rd_req),
        .ft_rd_ready          (ft_rd_ready),
        .rq_valid             (rq_valid),
        .rq_hdr               (rq_hdr),
        .rq_ready             (rq_ready)
    );

    response_router u_response_router (
        .clk                  (clk),
        .rst_n                (rst_n),
        .soft_rst_n           (soft_rst_n),
        .rsp_valid            (rsp_valid),
        .rsp                  (rsp),
        .ft_rx_valid          (ft_rx_valid),
        .ft_rx                (ft_rx)
    );

endmodule

`default_nettype wire

// File: sim/fpga_server_tb.sv
////////////////////////////////////////
// testbench for the server shell top
// host and thread models, scoreboards, watchdog
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "server_consts.svh"

module fpga_server_tb;

    localparam int RQ_PER_FT   = 24;
    localparam int RD_LIMIT    = 1000;
    localparam int RSP_CYCLES  = 200;
    localparam int JOB_CYCLES  = 400;
    // sum of the test lengths, then a margin
    localparam int TEST_CYCLES = 20 + 2 * RD_LIMIT + RSP_CYCLES + 2 * JOB_CYCLES;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 500;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          cci_rx_rd_valid;
    server_pkg::cci_rd_rsp_t       cci_rx_rd;
    logic                          cci_rx_cfg_valid;
    server_pkg::csr_wr_t           cci_rx_cfg;
    logic                          cci_tx_rd_almostfull;
    logic                          spl_tx_rd_valid;
    server_pkg::cci_rd_hdr_t       spl_tx_rd_hdr;
    logic [`NUM_FTHREADS-1:0]      ft_rd_valid;
    server_pkg::ft_rd_req_t        ft_rd_req [`NUM_FTHREADS];
    logic [`NUM_FTHREADS-1:0]      ft_rd_ready;
    logic [`NUM_FTHREADS-1:0]      ft_rx_valid;
    server_pkg::ft_rd_rsp_t        ft_rx [`NUM_FTHREADS];
    server_pkg::job_t              fthread_job [`NUM_FTHREADS];
    logic [`NUM_FTHREADS-1:0]      fthread_job_valid;
    logic [`NUM_FTHREADS-1:0]      fthread_done;
    logic [`NUM_FTHREADS-1:0]      ft_reset;

    integer  seed;
    int      errors = 0;
    int      n_checks = 0;
    int      n_tests = 0;
    int      err_mark = 0;
    string   cur_test = "none";
    logic    mon_en = 1'b0;

    // thread request model
    server_pkg::ft_rd_req_t    req_mem [`NUM_FTHREADS][RQ_PER_FT];
    int                        sent_idx [`NUM_FTHREADS];
    int                        got_idx [`NUM_FTHREADS];
    logic [`NUM_FTHREADS-1:0]  xfer = '0;
    logic                      rq_run = 1'b0;
    logic                      af_en = 1'b0;

    // response delay line, 3 cycles deep
    logic [2:0]                rsp_hist_v = '0;
    server_pkg::cci_rd_rsp_t   rsp_hist [3];

    // job model
    server_pkg::ft_state_e     ft_model [`NUM_FTHREADS];
    server_pkg::job_t          job_arg;

    fpga_server dut0 (
        .clk                  (clk),
        .rst_n                (rst_n),
        .cci_rx_rd_valid      (cci_rx_rd_valid),
        .cci_rx_rd            (cci_rx_rd),
        .cci_rx_cfg_valid     (cci_rx_cfg_valid),
        .cci_rx_cfg           (cci_rx_cfg),
        .cci_tx_rd_almostfull (cci_tx_rd_almostfull),
        .spl_tx_rd_valid      (spl_tx_rd_valid),
        .spl_tx_rd_hdr        (spl_tx_rd_hdr),
        .ft_rd_valid          (ft_rd_valid),
        .ft_rd_req            (ft_rd_req),
        .ft_rd_ready          (ft_rd_ready),
        .ft_rx_valid          (ft_rx_valid),
        .ft_rx                (ft_rx),
        .fthread_job          (fthread_job),
        .fthread_job_valid    (fthread_job_valid),
        .fthread_done         (fthread_done),
        .ft_reset             (ft_reset)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // check helpers
    ////////////////////////////////////////

    task automatic check_eq(input logic [79:0] exp, input logic [79:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %0h, actual %0h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic check_cond(input logic cond, input string what);
        n_checks++;
        assert (cond === 1'b1) else begin
            $display("[ERROR] %s: %s", cur_test, what);
            errors++;
        end
    endtask

    task automatic start_test(input string tname);
        cur_test = tname;
        err_mark = errors;
    endtask

    task automatic end_test();
        n_tests++;
        $display("test %0d %s: %s, %0d errors", n_tests, cur_test,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
    endtask

    ////////////////////////////////////////
    // thread models
    ////////////////////////////////////////

    // handshake seen at negedge, acted on at the next edge
    always @(negedge clk) begin
        xfer <= ft_rd_valid & ft_rd_ready;
    end

    // hold valid and request until ready, random gaps
    always @(posedge clk) begin
        int nxt;
        for (int i = 0; i < `NUM_FTHREADS; i++) begin
            nxt = sent_idx[i] + int'(xfer[i]);
            sent_idx[i] = nxt;
            if (!ft_rd_valid[i] || xfer[i]) begin
                if (rq_run && nxt < RQ_PER_FT && ($random(seed) & 3) != 0) begin
                    ft_rd_valid[i] <= 1'b1;
                    ft_rd_req[i]   <= req_mem[i][nxt];
                end else begin
                    ft_rd_valid[i] <= 1'b0;
                end
            end
        end
    end

    // host almost-full, random periods of a few cycles
    always @(posedge clk) begin
        if (!af_en) begin
            cci_tx_rd_almostfull <= 1'b0;
        end else if (($random(seed) & 7) == 0) begin
            cci_tx_rd_almostfull <= ~cci_tx_rd_almostfull;
        end
    end

    ////////////////////////////////////////
    // scoreboards
    ////////////////////////////////////////

    // host read requests, in order per thread
    always @(negedge clk) begin
        logic [`FT_ID_W-1:0]      tid;
        server_pkg::cci_rd_hdr_t  exp_hdr;
        if (mon_en) begin
            check_cond(!(spl_tx_rd_valid && cci_tx_rd_almostfull),
                       "read request strobed while host almost full");
            if (spl_tx_rd_valid) begin
                tid = spl_tx_rd_hdr.tag[`CCI_TAG_W-1 -: `FT_ID_W];
                check_cond(got_idx[tid] < RQ_PER_FT, "read request that no thread issued");
                if (got_idx[tid] < RQ_PER_FT) begin
                    exp_hdr.addr = req_mem[tid][got_idx[tid]].addr;
                    exp_hdr.tag  = {tid, req_mem[tid][got_idx[tid]].tag};
                    check_eq(exp_hdr, spl_tx_rd_hdr);
                    got_idx[tid]++;
                end
            end
        end
    end

    // read responses, 3 cycles after the host drove them
    always @(negedge clk) begin
        logic [`NUM_FTHREADS-1:0]  exp_v;
        logic [`FT_ID_W-1:0]       exp_tid;
        server_pkg::ft_rd_rsp_t    exp_rx;
        exp_tid = rsp_hist[2].tag[`CCI_TAG_W-1 -: `FT_ID_W];
        exp_v   = '0;
        if (rsp_hist_v[2]) begin
            exp_v[exp_tid] = 1'b1;
        end
        if (mon_en) begin
            check_eq(exp_v, ft_rx_valid);
            if (rsp_hist_v[2]) begin
                exp_rx.tag  = rsp_hist[2].tag[`FT_TAG_W-1:0];
                exp_rx.data = rsp_hist[2].data;
                check_eq(exp_rx, ft_rx[exp_tid]);
            end
        end
        rsp_hist_v  = {rsp_hist_v[1:0], cci_rx_rd_valid};
        rsp_hist[2] = rsp_hist[1];
        rsp_hist[1] = rsp_hist[0];
        rsp_hist[0] = cci_rx_rd;
    end

    ////////////////////////////////////////
    // read request tests
    ////////////////////////////////////////

    function automatic logic reads_done();
        logic ok;
        ok = 1'b1;
        for (int t = 0; t < `NUM_FTHREADS; t++) begin
            ok = ok && (got_idx[t] == RQ_PER_FT);
        end
        return ok;
    endfunction

    task automatic run_reads(input logic with_af);
        logic [31:0] r;
        for (int t = 0; t < `NUM_FTHREADS; t++) begin
            for (int k = 0; k < RQ_PER_FT; k++) begin
                r = $random(seed);
                req_mem[t][k].addr = r;
                r = $random(seed);
                req_mem[t][k].tag = r[`FT_TAG_W-1:0];
            end
            sent_idx[t] = 0;
            got_idx[t]  = 0;
        end
        @(negedge clk);
        af_en  = with_af;
        rq_run = 1'b1;
        for (int c = 0; c < RD_LIMIT && !reads_done(); c++) begin
            @(negedge clk);
        end
        check_cond(reads_done(), "read requests still missing at the host");
        rq_run = 1'b0;
        af_en  = 1'b0;
        repeat (6) @(negedge clk);
    endtask

    // host pushes random responses, roughly every other cycle
    task automatic run_responses();
        server_pkg::cci_rd_rsp_t  r;
        logic [31:0]              v;
        for (int n = 0; n < RSP_CYCLES; n++) begin
            @(posedge clk);
            v      = $random(seed);
            r.tag  = v[`CCI_TAG_W-1:0];
            r.data = {$random(seed), $random(seed)};
            cci_rx_rd_valid <= v[16];
            cci_rx_rd       <= r;
        end
        @(posedge clk);
        cci_rx_rd_valid <= 1'b0;
        repeat (5) @(posedge clk);
    endtask

    ////////////////////////////////////////
    // CSR and job tests
    ////////////////////////////////////////

    // one-cycle CSR write strobe
    task automatic csr_write(input logic [`CSR_ADDR_W-1:0] addr,
                             input logic [`CSR_DATA_W-1:0] data);
        server_pkg::csr_wr_t w;
        w.addr = addr;
        w.data = data;
        @(posedge clk);
        cci_rx_cfg_valid <= 1'b1;
        cci_rx_cfg       <= w;
        @(posedge clk);
        cci_rx_cfg_valid <= 1'b0;
        if (addr == `CSR_JOB_ARG_ADDR) begin
            job_arg = data;
        end
    endtask

    task automatic write_job(input int t);
        server_pkg::job_t j;
        logic [31:0]      r;
        r         = $random(seed);
        j.ft_id   = t[`FT_ID_W-1:0];
        j.payload = r[`CSR_DATA_W-`FT_ID_W-1:0];
        csr_write(`CSR_JOB_ARG_ADDR, j);
    endtask

    // command at the host, result 3 cycles after the drive edge
    task automatic send_cmd(input server_pkg::cmd_opcode_e op);
        logic [`NUM_FTHREADS-1:0] exp_v;
        logic [`NUM_FTHREADS-1:0] exp_rst;
        exp_v   = '0;
        exp_rst = '0;
        if (op == server_pkg::OP_START_JOB &&
            ft_model[job_arg.ft_id] == server_pkg::FT_IDLE) begin
            exp_v[job_arg.ft_id]    = 1'b1;
            ft_model[job_arg.ft_id] = server_pkg::FT_BUSY;
        end
        if (op == server_pkg::OP_SOFT_RESET) begin
            exp_rst = '1;
            for (int i = 0; i < `NUM_FTHREADS; i++) begin
                ft_model[i] = server_pkg::FT_IDLE;
            end
        end
        csr_write(`CSR_CMD_ADDR, `CSR_DATA_W'(op));
        // still in the receive registers
        repeat (2) begin
            @(negedge clk);
            check_eq(0, fthread_job_valid);
            check_eq(0, ft_reset);
        end
        @(negedge clk);
        check_eq(exp_v, fthread_job_valid);
        check_eq(exp_rst, ft_reset);
        if (exp_v != 0) begin
            check_eq(job_arg, fthread_job[job_arg.ft_id]);
        end
        // pulses last one cycle
        @(negedge clk);
        check_eq(0, fthread_job_valid);
        check_eq(0, ft_reset);
    endtask

    task automatic send_done(input int t);
        @(posedge clk);
        fthread_done <= `NUM_FTHREADS'(1) << t;
        @(posedge clk);
        fthread_done <= '0;
        ft_model[t] = server_pkg::FT_IDLE;
    endtask

    task automatic run_jobs();
        // first start per thread goes through
        for (int t = 0; t < `NUM_FTHREADS; t++) begin
            write_job(t);
            send_cmd(server_pkg::OP_START_JOB);
        end
        // all busy, every start dropped
        for (int t = 0; t < `NUM_FTHREADS; t++) begin
            write_job(t);
            send_cmd(server_pkg::OP_START_JOB);
        end
        for (int t = 0; t < `NUM_FTHREADS; t++) begin
            send_done(t);
            write_job(t);
            send_cmd(server_pkg::OP_START_JOB);
            send_done(t);
        end
    endtask

    task automatic run_soft_reset();
        logic [31:0] r;
        int          t;
        r = $random(seed);
        t = int'(r[`FT_ID_W-1:0]);
        write_job(t);
        send_cmd(server_pkg::OP_START_JOB);
        send_cmd(server_pkg::OP_SOFT_RESET);
        // thread state cleared, no done needed
        write_job(t);
        send_cmd(server_pkg::OP_START_JOB);
        send_done(t);
        repeat (2) @(negedge clk);
    endtask

    ////////////////////////////////////////
    // run
    ////////////////////////////////////////

    initial begin
        seed                 = 32'haf17;
        rst_n                = 1'b0;
        cci_rx_rd_valid      = 1'b0;
        cci_rx_rd            = '0;
        cci_rx_cfg_valid     = 1'b0;
        cci_rx_cfg           = '0;
        cci_tx_rd_almostfull = 1'b0;
        ft_rd_valid          = '0;
        fthread_done         = '0;
        job_arg              = '0;
        for (int i = 0; i < `NUM_FTHREADS; i++) begin
            ft_rd_req[i] = '0;
            ft_model[i]  = server_pkg::FT_IDLE;
            sent_idx[i]  = 0;
            got_idx[i]   = RQ_PER_FT;
        end
        repeat (2) @(posedge clk);
        rst_n  <= 1'b1;
        mon_en = 1'b1;

        start_test("reset_state");
        repeat (4) begin
            @(negedge clk);
            check_eq(0, spl_tx_rd_valid);
            check_eq(0, ft_rx_valid);
            check_eq(0, fthread_job_valid);
            check_eq(0, ft_reset);
            check_eq({`NUM_FTHREADS{1'b1}}, ft_rd_ready);
        end
        end_test();

        start_test("random_reads");
        run_reads(1'b0);
        end_test();

        start_test("reads_almostfull");
        run_reads(1'b1);
        end_test();

        start_test("read_responses");
        run_responses();
        end_test();

        start_test("job_dispatch");
        run_jobs();
        end_test();

        start_test("soft_reset");
        run_soft_reset();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // stops a hung run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: fpga_server.f
+incdir+hdl
hdl/server_pkg.sv
hdl/server_io.sv
hdl/cmd_server.sv
hdl/read_arbiter.sv
hdl/response_router.sv
hdl/fpga_server.sv
sim/fpga_server_tb.sv

// File: Bender.yml
package:
  name: fpga_server

sources:
  # RTL, package first
  - include_dirs:
      - hdl
    files:
      - hdl/server_pkg.sv
      - hdl/server_io.sv
      - hdl/cmd_server.sv
      - hdl/read_arbiter.sv
      - hdl/response_router.sv
      - hdl/fpga_server.sv

  # testbench
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/fpga_server_tb.sv
